// ==== src/axi_mem_params.svh ====
`ifndef AXI_MEM_PARAMS_SVH
`define AXI_MEM_PARAMS_SVH

// bus widths
`define AXI_MEM_ADDR_W 32
`define AXI_MEM_DATA_W 32
`define AXI_MEM_STRB_W 4 // one strobe per data byte

// word array depth
// 256 words covers byte addresses 0 to 1023
`define AXI_MEM_WORDS 256

// response latencies in clock edges
// counted from the request handshake edge to the response valid edge
`define AXI_MEM_READ_LAT 8
`define AXI_MEM_WRITE_LAT 6

`endif

// ==== src/axi_mem_pkg.sv ====
`include "axi_mem_params.svh"

package axi_mem_pkg;

	// response codes, EXOKAY and DECERR never produced
	typedef enum logic [1:0] {
		OKAY   = 2'd0,
		SLVERR = 2'd2
	} axi_resp_e;

	// read address channel
	typedef struct packed {
		logic [`AXI_MEM_ADDR_W-1:0] addr;
	} axi_ar_t;

	// write address channel
	typedef struct packed {
		logic [`AXI_MEM_ADDR_W-1:0] addr;
	} axi_aw_t;

	// write data channel
	typedef struct packed {
		logic [`AXI_MEM_DATA_W-1:0] data;
		logic [`AXI_MEM_STRB_W-1:0] strb; // byte enables, bit n covers data[8n+7:8n]
	} axi_w_t;

	// read data channel
	typedef struct packed {
		logic [`AXI_MEM_DATA_W-1:0] data;
		axi_resp_e                  resp;
	} axi_r_t;

	// write response channel
	typedef struct packed {
		axi_resp_e resp;
	} axi_b_t;

	// transaction states
	// one transaction in flight at a time, reads and writes never overlap
	typedef enum logic [2:0] {
		IDLE       = 3'd0, // request readies high
		READ_WAIT  = 3'd1, // read latency running
		READ_RESP  = 3'd2, // read data loaded, waiting for handshake
		WRITE_WAIT = 3'd3, // write latency running
		WRITE_RESP = 3'd4  // write response held
	} mem_state_e;

endpackage

// ==== src/latency_timer.sv ====
`timescale 1ns/100ps

module latency_timer (
	input  logic       clk,
	input  logic       rstn,
	input  logic       load_i,
	input  logic [3:0] value_i,
	output logic       done_o
);

	logic [3:0] count_q;
	logic       busy_q; // a loaded count is running

	// load wins over the running count
	always_ff @(posedge clk) begin
		if (rstn) begin
			count_q <= '0;
			busy_q  <= 1'b0;
		end else if (load_i) begin
			count_q <= value_i;
			busy_q  <= 1'b1;
		end else if (busy_q) begin
			if (count_q == 4'd0) begin
				busy_q <= 1'b0; // expired, back to idle
			end else begin
				count_q <= count_q - 4'd1;
			end
		end
	end

	// value_i + 1 cycles after the load edge, single cycle
	assign done_o = busy_q && (count_q == 4'd0);

endmodule

// ==== src/sram_array.sv ====
`timescale 1ns/100ps
`include "axi_mem_params.svh"

module sram_array import axi_mem_pkg::*; #(
	parameter int WORDS = `AXI_MEM_WORDS
) (
	input  logic                       clk,
	input  logic                       rstn,
	input  logic                       ren_i,
	input  logic                       wen_i,
	input  logic [$clog2(WORDS)-1:0]   index_i,
	input  axi_w_t                     w_i,
	output logic [`AXI_MEM_DATA_W-1:0] rdata_o
);

	logic [`AXI_MEM_DATA_W-1:0] mem_q [WORDS];
	logic [`AXI_MEM_DATA_W-1:0] rdata_q;

	// overlay the strobed bytes of wr onto old_word
	function automatic logic [`AXI_MEM_DATA_W-1:0] merge_word(
		input logic [`AXI_MEM_DATA_W-1:0] old_word,
		input axi_w_t                     wr
	);
		logic [`AXI_MEM_DATA_W-1:0] merged;
		merged = old_word;
		for (int b = 0; b < `AXI_MEM_STRB_W; b++) begin
			if (wr.strb[b]) begin
				merged[8*b +: 8] = wr.data[8*b +: 8];
			end
		end
		return merged;
	endfunction

	// every word cleared while in reset
	always_ff @(posedge clk) begin
		if (rstn) begin
			for (int i = 0; i < WORDS; i++) begin
				mem_q[i] <= '0;
			end
		end else if (wen_i) begin
			mem_q[index_i] <= merge_word(mem_q[index_i], w_i); // takes effect at this edge
		end
	end

	// registered read, data valid the cycle after ren_i
	always_ff @(posedge clk) begin
		if (ren_i) begin
			rdata_q <= mem_q[index_i];
		end
	end

	assign rdata_o = rdata_q;

endmodule

// ==== src/resp_holder.sv ====
`timescale 1ns/100ps

// one response slot for a valid/ready channel
// loaded by the fsm, drained by the bus master
module resp_holder #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rstn,
	input  logic     load_i,
	input  payload_t payload_i,
	input  logic     ready_i,
	output payload_t payload_o,
	output logic     valid_o,
	output logic     accept_o
);

	payload_t payload_q;
	logic     valid_q;

	// handshake cycle
	assign accept_o = valid_q && ready_i;

	always_ff @(posedge clk) begin
		if (rstn) begin
			valid_q <= 1'b0;
		end else if (load_i) begin
			valid_q <= 1'b1; // rises the edge after load
		end else if (accept_o) begin
			valid_q <= 1'b0; // falls on the handshake edge
		end
	end

	// payload frozen while valid is up
	// the fsm never loads during a pending response
	always_ff @(posedge clk) begin
		if (load_i) begin
			payload_q <= payload_i;
		end
	end

	assign payload_o = payload_q;
	assign valid_o   = valid_q;

endmodule

// ==== src/axi_mem_fsm.sv ====
`timescale 1ns/100ps
`include "axi_mem_params.svh"

module axi_mem_fsm import axi_mem_pkg::*; (
	input  logic                              clk,
	input  logic                              rstn,
	input  axi_ar_t                           ar_i,
	input  logic                              ar_valid_i,
	output logic                              ar_ready_o,
	input  axi_aw_t                           aw_i,
	input  logic                              aw_valid_i,
	output logic                              aw_ready_o,
	input  axi_w_t                            w_i,
	input  logic                              w_valid_i,
	output logic                              w_ready_o,
	input  logic                              timer_done_i,
	output logic                              timer_load_o,
	output logic [3:0]                        timer_value_o,
	output logic                              mem_ren_o,
	output logic                              mem_wen_o,
	output logic [$clog2(`AXI_MEM_WORDS)-1:0] mem_index_o,
	output axi_w_t                            mem_w_o,
	output logic                              r_load_o,
	output logic                              r_err_o,
	input  logic                              r_accept_i,
	output logic                              b_load_o,
	output axi_b_t                            b_o,
	input  logic                              b_accept_i
);

	localparam int IDX_W = $clog2(`AXI_MEM_WORDS);

	// read path spends one extra edge in the array register
	localparam logic [3:0] READ_VAL  = 4'(`AXI_MEM_READ_LAT - 2);
	localparam logic [3:0] WRITE_VAL = 4'(`AXI_MEM_WRITE_LAT - 1);

	mem_state_e state_q, state_d;

	logic                       idle;
	logic                       rd_req;
	logic                       wr_req;
	logic [`AXI_MEM_ADDR_W-1:0] req_addr;
	logic                       err_d;
	logic                       err_q;
	logic                       ren_q; // array data lands this cycle
	logic [`AXI_MEM_ADDR_W-1:0] addr_q;
	axi_w_t                     wdata_q;

	assign idle = (state_q == IDLE);

	// same readiness on all three request channels
	assign ar_ready_o = idle;
	assign aw_ready_o = idle;
	assign w_ready_o  = idle;

	// read has priority, write needs address and data together
	assign rd_req = idle && ar_valid_i;
	assign wr_req = idle && !ar_valid_i && aw_valid_i && w_valid_i;

	// range check on the word index, low bits ignored
	assign req_addr = rd_req ? ar_i.addr : aw_i.addr;
	assign err_d    = (req_addr >> 2) >= `AXI_MEM_WORDS;

	assign timer_load_o  = rd_req || wr_req;
	assign timer_value_o = rd_req ? READ_VAL : WRITE_VAL;

	assign mem_ren_o   = (state_q == READ_WAIT) && timer_done_i;
	assign mem_wen_o   = (state_q == WRITE_WAIT) && timer_done_i && !err_q; // bad writes dropped
	assign mem_index_o = addr_q[IDX_W+1:2];
	assign mem_w_o     = wdata_q;

	assign r_load_o = ren_q;
	assign r_err_o  = err_q;
	assign b_load_o = (state_q == WRITE_WAIT) && timer_done_i;
	assign b_o      = '{resp: (err_q ? SLVERR : OKAY)};

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (rd_req) begin
					state_d = READ_WAIT;
				end else if (wr_req) begin
					state_d = WRITE_WAIT;
				end
			end
			READ_WAIT:  if (timer_done_i) state_d = READ_RESP;
			READ_RESP:  if (r_accept_i)   state_d = IDLE;
			WRITE_WAIT: if (timer_done_i) state_d = WRITE_RESP;
			WRITE_RESP: if (b_accept_i)   state_d = IDLE;
			default:    state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rstn) begin
			state_q <= IDLE;
			err_q   <= 1'b0;
			ren_q   <= 1'b0;
		end else begin
			state_q <= state_d;
			ren_q   <= mem_ren_o;
			if (timer_load_o) err_q <= err_d;
		end
	end

	// request capture on the accepting edge
	always_ff @(posedge clk) begin
		if (rd_req) begin
			addr_q <= ar_i.addr;
		end else if (wr_req) begin
			addr_q  <= aw_i.addr;
			wdata_q <= w_i;
		end
	end

endmodule

// ==== src/axi_mem_top.sv ====
`timescale 1ns/100ps
`include "axi_mem_params.svh"

module axi_mem_top import axi_mem_pkg::*; (
	input  logic    clk,
	input  logic    rstn,
	input  axi_ar_t ar_i,
	input  logic    ar_valid_i,
	output logic    ar_ready_o,
	input  axi_aw_t aw_i,
	input  logic    aw_valid_i,
	output logic    aw_ready_o,
	input  axi_w_t  w_i,
	input  logic    w_valid_i,
	output logic    w_ready_o,
	output axi_r_t  r_o,
	output logic    r_valid_o,
	input  logic    r_ready_i,
	output axi_b_t  b_o,
	output logic    b_valid_o,
	input  logic    b_ready_i
);

	logic                              timer_load;
	logic [3:0]                        timer_value;
	logic                              timer_done;
	logic                              mem_ren;
	logic                              mem_wen;
	logic [$clog2(`AXI_MEM_WORDS)-1:0] mem_index;
	axi_w_t                            mem_w;
	logic [`AXI_MEM_DATA_W-1:0]        mem_rdata;
	logic                              r_load;
	logic                              r_err;
	logic                              r_accept;
	logic                              b_load;
	axi_b_t                            b_payload;
	logic                              b_accept;
	axi_r_t                            r_payload;

	axi_mem_fsm fsm_inst (
		.clk(clk), .rstn(rstn),
		.ar_i(ar_i), .ar_valid_i(ar_valid_i), .ar_ready_o(ar_ready_o),
		.aw_i(aw_i), .aw_valid_i(aw_valid_i), .aw_ready_o(aw_ready_o),
		.w_i(w_i), .w_valid_i(w_valid_i), .w_ready_o(w_ready_o),
		.timer_done_i(timer_done), .timer_load_o(timer_load), .timer_value_o(timer_value),
		.mem_ren_o(mem_ren), .mem_wen_o(mem_wen), .mem_index_o(mem_index), .mem_w_o(mem_w),
		.r_load_o(r_load), .r_err_o(r_err), .r_accept_i(r_accept),
		.b_load_o(b_load), .b_o(b_payload), .b_accept_i(b_accept)
	);

	latency_timer timer_inst (
		.clk(clk), .rstn(rstn),
		.load_i(timer_load), .value_i(timer_value), .done_o(timer_done)
	);

	sram_array #(.WORDS(`AXI_MEM_WORDS)) sram_inst (
		.clk(clk), .rstn(rstn),
		.ren_i(mem_ren), .wen_i(mem_wen), .index_i(mem_index), .w_i(mem_w),
		.rdata_o(mem_rdata)
	);

	// array word plus response code, data still returned on SLVERR
	assign r_payload = '{data: mem_rdata, resp: (r_err ? SLVERR : OKAY)};

	resp_holder #(.payload_t(axi_r_t)) r_holder_inst (
		.clk(clk), .rstn(rstn),
		.load_i(r_load), .payload_i(r_payload), .ready_i(r_ready_i),
		.payload_o(r_o), .valid_o(r_valid_o), .accept_o(r_accept)
	);

	resp_holder #(.payload_t(axi_b_t)) b_holder_inst (
		.clk(clk), .rstn(rstn),
		.load_i(b_load), .payload_i(b_payload), .ready_i(b_ready_i),
		.payload_o(b_o), .valid_o(b_valid_o), .accept_o(b_accept)
	);

endmodule

// ==== tests/axi_mem_chk.sv ====
`timescale 1ns/100ps

module axi_mem_chk import axi_mem_pkg::*; (
	input logic       clk,
	input logic       rstn,
	input mem_state_e state_i,
	input logic       ar_ready_i,
	input logic       aw_ready_i,
	input logic       w_ready_i,
	input axi_r_t     r_i,
	input logic       r_valid_i,
	input logic       r_ready_i,
	input axi_b_t     b_i,
	input logic       b_valid_i,
	input logic       b_ready_i
);

	int fail_count = 0; // read by the testbench at the end

	// pending read response held until taken
	r_hold: assert property (@(posedge clk) disable iff (rstn)
		r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_i))
		else begin
			$error("read response dropped or changed before r_ready_i");
			fail_count++;
		end

	b_hold: assert property (@(posedge clk) disable iff (rstn)
		b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_i))
		else begin
			$error("write response dropped or changed before b_ready_i");
			fail_count++;
		end

	// requests only taken in IDLE
	req_ready_idle: assert property (@(posedge clk) disable iff (rstn)
		state_i != IDLE |-> !ar_ready_i && !aw_ready_i && !w_ready_i)
		else begin
			$error("request ready high outside IDLE");
			fail_count++;
		end

	one_resp: assert property (@(posedge clk) disable iff (rstn) !(r_valid_i && b_valid_i))
		else begin
			$error("r_valid_o and b_valid_o high together");
			fail_count++;
		end

endmodule

bind axi_mem_top axi_mem_chk chk_inst (
	.clk(clk), .rstn(rstn), .state_i(fsm_inst.state_q),
	.ar_ready_i(ar_ready_o), .aw_ready_i(aw_ready_o), .w_ready_i(w_ready_o),
	.r_i(r_o), .r_valid_i(r_valid_o), .r_ready_i(r_ready_i),
	.b_i(b_o), .b_valid_i(b_valid_o), .b_ready_i(b_ready_i)
);

// ==== tests/axi_mem_tb.sv ====
`timescale 1ns/100ps
`include "axi_mem_params.svh"

module axi_mem_tb import axi_mem_pkg::*; ();

	localparam int WAIT_LIMIT = 100;

	typedef struct {
		bit     is_read;
		axi_r_t exp_r;
		axi_b_t exp_b;
		int     hs_cycle; // cycle count just after the request handshake edge
		int     stall;    // cycles of ready held low once valid is seen
	} exp_item_t;

	logic    clk;
	logic    rstn;
	axi_ar_t ar_i;
	logic    ar_valid_i;
	logic    ar_ready_o;
	axi_aw_t aw_i;
	logic    aw_valid_i;
	logic    aw_ready_o;
	axi_w_t  w_i;
	logic    w_valid_i;
	logic    w_ready_o;
	axi_r_t  r_o;
	logic    r_valid_o;
	logic    r_ready_i;
	axi_b_t  b_o;
	logic    b_valid_o;
	logic    b_ready_i;

	logic [`AXI_MEM_DATA_W-1:0] model [`AXI_MEM_WORDS];
	exp_item_t                  exp_q [$];
	string                      test_name = "reset";
	bit                         ready_high = 1'b1; // response readies idle high
	int                         cycle_cnt = 0;

	axi_mem_top axi_mem_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic stop_run();
		$display("Test failures found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_failure(input string what);
		$display("ERROR in %s: %s", test_name, what);
		stop_run();
	endtask

	// bound protocol assertions end the run at their first failure
	always @(axi_mem_top_inst.chk_inst.fail_count) begin
		if (axi_mem_top_inst.chk_inst.fail_count != 0) begin
			report_failure("a protocol assertion failed");
		end
	end

	task automatic check_r(input string name, input axi_r_t exp, input axi_r_t act);
		if (act !== exp) begin
			$display("MISMATCH %s: expected data %h resp %0d, actual data %h resp %0d",
				name, exp.data, exp.resp, act.data, act.resp);
			stop_run();
		end
	endtask

	task automatic check_b(input string name, input axi_b_t exp, input axi_b_t act);
		if (act !== exp) begin
			$display("MISMATCH %s: expected resp %0d, actual resp %0d", name, exp.resp, act.resp);
			stop_run();
		end
	endtask

	task automatic check_latency(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("MISMATCH %s: expected latency %0d, actual latency %0d", name, exp, act);
			stop_run();
		end
	endtask

	// old bytes kept where the strobe is low
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word, input axi_w_t wr);
		logic [31:0] mask;
		for (int b = 0; b < 4; b++) begin
			mask[8*b +: 8] = {8{wr.strb[b]}};
		end
		return (old_word & ~mask) | (wr.data & mask);
	endfunction

	function automatic axi_resp_e expect_resp(input logic [31:0] addr);
		return (addr < 4 * `AXI_MEM_WORDS) ? OKAY : SLVERR;
	endfunction

	function automatic int word_of(input logic [31:0] addr);
		return (addr >> 2) % `AXI_MEM_WORDS;
	endfunction

	function automatic logic [31:0] random_addr();
		if ($urandom_range(0, 9) == 0) begin
			return $urandom() | 32'h400; // at or above 1024
		end
		return 32'($urandom_range(0, 4 * `AXI_MEM_WORDS - 1));
	endfunction

	function automatic axi_w_t random_w();
		axi_w_t wr;
		wr.data = $urandom();
		wr.strb = 4'($urandom_range(0, 15));
		return wr;
	endfunction

	// expected response, model updated at the handshake
	task automatic push_item(input bit is_read, input logic [31:0] addr, input axi_w_t wr);
		exp_item_t item;
		item.is_read = is_read;
		item.exp_r = '{data: model[word_of(addr)], resp: expect_resp(addr)};
		item.exp_b = '{resp: expect_resp(addr)};
		item.hs_cycle = cycle_cnt;
		item.stall = ready_high ? 0 : $urandom_range(0, 6);
		if (!is_read && expect_resp(addr) == OKAY) begin
			model[word_of(addr)] = merge_bytes(model[word_of(addr)], wr);
		end
		exp_q.push_back(item);
	endtask

	task automatic wait_req_ready(input bit is_write);
		int waited;
		waited = 0;
		while (is_write ? !(aw_ready_o && w_ready_o) : !ar_ready_o) begin
			tick();
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_failure(is_write ? "aw_ready_o and w_ready_o never rose"
					: "ar_ready_o never rose");
			end
		end
	endtask

	task automatic do_read(input logic [31:0] addr);
		ar_i = '{addr: addr};
		ar_valid_i = 1'b1;
		wait_req_ready(1'b0);
		tick(); // handshake edge
		ar_valid_i = 1'b0;
		push_item(1'b1, addr, w_i);
	endtask

	task automatic do_write(input logic [31:0] addr, input axi_w_t wr);
		aw_i = '{addr: addr};
		w_i = wr;
		aw_valid_i = 1'b1;
		w_valid_i = 1'b1;
		wait_req_ready(1'b1);
		tick();
		aw_valid_i = 1'b0;
		w_valid_i = 1'b0;
		push_item(1'b0, addr, wr);
	endtask

	// read and write offered on the same edge
	task automatic do_both(input logic [31:0] raddr, input logic [31:0] waddr, input axi_w_t wr);
		ar_i = '{addr: raddr};
		aw_i = '{addr: waddr};
		w_i = wr;
		ar_valid_i = 1'b1;
		aw_valid_i = 1'b1;
		w_valid_i = 1'b1;
		wait_req_ready(1'b0);
		tick();
		ar_valid_i = 1'b0;
		push_item(1'b1, raddr, wr);
		wait_req_ready(1'b1); // write still pending behind the read
		tick();
		aw_valid_i = 1'b0;
		w_valid_i = 1'b0;
		push_item(1'b0, waddr, wr);
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0) begin
			tick();
			waited++;
			if (waited > 4 * WAIT_LIMIT) report_failure("responses still outstanding");
		end
		tick();
	endtask

	// response collector and compare
	initial begin : compare_proc
		exp_item_t item;
		int        waited;
		r_ready_i = 1'b0;
		b_ready_i = 1'b0;
		forever begin
			if (exp_q.size() == 0) begin
				r_ready_i = ready_high;
				b_ready_i = ready_high;
				tick();
			end else begin
				item = exp_q[0];
				waited = 0;
				while (!(item.is_read ? r_valid_o : b_valid_o)) begin
					if (item.is_read ? b_valid_o : r_valid_o) begin
						report_failure("response came back on the wrong channel");
					end
					tick();
					waited++;
					if (waited > WAIT_LIMIT) begin
						report_failure(item.is_read ? "r_valid_o never rose" : "b_valid_o never rose");
					end
				end
				check_latency(test_name, item.is_read ? `AXI_MEM_READ_LAT : `AXI_MEM_WRITE_LAT,
					cycle_cnt - item.hs_cycle);
				repeat (item.stall) begin
					if (ar_ready_o || aw_ready_o || w_ready_o) begin
						report_failure("request ready high while a response is held");
					end
					tick();
				end
				if (item.is_read) begin
					check_r(test_name, item.exp_r, r_o);
					r_ready_i = 1'b1;
				end else begin
					check_b(test_name, item.exp_b, b_o);
					b_ready_i = 1'b1;
				end
				tick(); // response handshake edge
				r_ready_i = ready_high;
				b_ready_i = ready_high;
				void'(exp_q.pop_front());
			end
		end
	end

	initial begin : stimulus
		logic [31:0] addr;
		axi_w_t      wr;
		void'($urandom(75111));
		rstn = 1'b1;
		ar_i = '0;
		ar_valid_i = 1'b0;
		aw_i = '0;
		aw_valid_i = 1'b0;
		w_i = '0;
		w_valid_i = 1'b0;
		foreach (model[i]) model[i] = '0; // array clears on reset
		repeat (3) @(posedge clk);
		#2;
		rstn = 1'b0;
		tick();

		test_name = "full_strobe";
		for (int i = 0; i < 8; i++) begin
			wr = random_w();
			wr.strb = 4'hf;
			do_write(32'(i * 36), wr);
			do_read(32'(i * 36));
		end
		drain();

		test_name = "partial_strobe";
		for (int s = 1; s < 16; s++) begin
			wr = random_w();
			wr.strb = 4'(s);
			do_write(32'h40, wr);
			do_read(32'h40);
		end
		drain();

		test_name = "out_of_range";
		wr = random_w();
		wr.strb = 4'hf;
		do_write(32'h10, wr);
		for (int k = 0; k < 4; k++) begin
			addr = 32'h400 * (k + 1) + 32'h10; // aliases word 4
			wr = random_w();
			wr.strb = 4'hf; // every byte would show if the write leaked
			do_write(addr, wr);
			do_read(addr);
			do_read(32'h10);
		end
		do_read(32'hffff_fffc);
		drain();

		test_name = "fixed_latency";
		for (int i = 0; i < 6; i++) begin
			do_write(32'(i * 4), random_w());
			drain();
			do_read(32'(i * 4));
			drain();
		end

		test_name = "back_pressure";
		ready_high = 1'b0;
		for (int i = 0; i < 24; i++) begin
			addr = 32'($urandom_range(0, 4 * `AXI_MEM_WORDS - 1));
			if ($urandom_range(0, 1) == 1) do_read(addr);
			else do_write(addr, random_w());
		end
		drain();

		test_name = "read_priority";
		for (int i = 0; i < 4; i++) begin
			do_both(32'(i * 8), 32'(i * 8), random_w());
		end
		drain();

		test_name = "random_traffic";
		for (int n = 0; n < 400; n++) begin
			addr = random_addr();
			if ($urandom_range(0, 1) == 1) do_read(addr);
			else do_write(addr, random_w());
		end
		drain();

		if (axi_mem_top_inst.chk_inst.fail_count == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			$display("Test failures found");
			$fatal(1, "protocol assertions failed");
		end
	end

endmodule

// ==== tb.f ====
+incdir+src
src/axi_mem_pkg.sv
src/latency_timer.sv
src/sram_array.sv
src/resp_holder.sv
src/axi_mem_fsm.sv
src/axi_mem_top.sv
tests/axi_mem_chk.sv
tests/axi_mem_tb.sv

// ==== Bender.yml ====
package:
  name: axi_mem

sources:
  - include_dirs:
      - src
    files:
      - src/axi_mem_pkg.sv
      - src/latency_timer.sv
      - src/sram_array.sv
      - src/resp_holder.sv
      - src/axi_mem_fsm.sv
      - src/axi_mem_top.sv

  - target: test
    include_dirs:
      - src
    files:
      - tests/axi_mem_chk.sv
      - tests/axi_mem_tb.sv
